//--- compile.f
design/axi_slv_pkg.sv
design/burst_addr_gen.sv
design/slv_mem.sv
design/axi_burst_ctrl.sv
design/axi_full_slv.sv
testbench/axi_full_slv_sva.sv
testbench/tb_axi_full_slv.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_axi_full_slv -Mdir obj_dir -f compile.f; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_axi_full_slv)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi

echo "Pass message not found in the simulation output"
exit 1

//--- testbench/tb_axi_full_slv.sv
/*
 * Directed testbench of the AXI4 burst slave, run with a 64-word memory.
 * Stops at the first mismatch. Words are written before they are read back.
 */

`timescale 1ns/100ps

module tb_axi_full_slv;

	localparam int MEM_WORDS = 64;
	localparam int TIMEOUT   = 200;

	logic                  CLK;
	logic                  rst_n;
	axi_slv_pkg::axi_req_t aw;
	logic                  aw_valid;
	logic                  aw_ready;
	axi_slv_pkg::w_beat_t  w;
	logic                  w_valid;
	logic                  w_ready;
	axi_slv_pkg::b_resp_t  b;
	logic                  b_valid;
	logic                  b_ready;
	axi_slv_pkg::axi_req_t ar;
	logic                  ar_valid;
	logic                  ar_ready;
	axi_slv_pkg::r_beat_t  r;
	logic                  r_valid;
	logic                  r_ready;

	logic [7:0]  ref_mem [MEM_WORDS*4];
	logic [31:0] lfsr;
	logic [31:0] wdata_q [$];
	logic [3:0]  wstrb_q [$];
	logic        stall_en;
	time         b_done_t;
	time         ar_done_t;

	axi_full_slv #(.MEM_WORDS(MEM_WORDS)) UUT (.*);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Random source, reporting and reference model.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Taps of x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic ready_draw();
		logic [31:0] v;
		v = rand_bits(1);
		return !stall_en || v[0];
	endfunction

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			stop_with_failure($sformatf("Error at %0d ns: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic tick();
		@(posedge CLK);
		#1;
	endtask

	// Next word of a burst; a WRAP window is len+1 words on its own boundary.
	function automatic int next_word(input int wa, input int len,
			input axi_slv_pkg::burst_e bt);
		int base;
		base = wa - (wa % (len + 1));
		case (bt)
			axi_slv_pkg::BURST_FIXED: return wa;
			axi_slv_pkg::BURST_WRAP:  return base + (wa + 1 - base) % (len + 1);
			default:                  return wa + 1;
		endcase
	endfunction

	function automatic logic [31:0] ref_word(input int wa);
		return {ref_mem[wa*4+3], ref_mem[wa*4+2], ref_mem[wa*4+1], ref_mem[wa*4]};
	endfunction

	function automatic axi_slv_pkg::axi_req_t make_req(input logic [3:0] id,
			input int start, input int len, input axi_slv_pkg::burst_e bt);
		axi_slv_pkg::axi_req_t req;
		req.id    = id;
		req.addr  = 32'(start * 4);
		req.len   = 8'(len);
		req.burst = bt;
		return req;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus driver tasks. Each starts and ends 1 ns after a rising edge.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic send_aw(input axi_slv_pkg::axi_req_t req);
		int n;
		n        = 0;
		aw       = req;
		aw_valid = 1'b1;
		while (!aw_ready) begin
			tick();
			n++;
			if (n > TIMEOUT) stop_with_failure("Write address was never accepted");
		end
		tick();
		aw_valid = 1'b0;
	endtask

	task automatic send_ar(input axi_slv_pkg::axi_req_t req);
		int n;
		n        = 0;
		ar       = req;
		ar_valid = 1'b1;
		while (!ar_ready) begin
			tick();
			n++;
			if (n > TIMEOUT) stop_with_failure("Read address was never accepted");
		end
		tick();
		ar_valid  = 1'b0;
		ar_done_t = $time;
	endtask

	task automatic send_w_burst();
		int n;
		for (int i = 0; i < wdata_q.size(); i++) begin
			if (!ready_draw()) begin
				w_valid = 1'b0;
				tick();
			end
			w.data  = wdata_q[i];
			w.strb  = wstrb_q[i];
			w.last  = (i == wdata_q.size() - 1);
			w_valid = 1'b1;
			n = 0;
			while (!w_ready) begin
				tick();
				n++;
				if (n > TIMEOUT) stop_with_failure("Write beat was never accepted");
			end
			tick();
		end
		w_valid = 1'b0;
	endtask

	task automatic take_b(input logic [3:0] exp_id, input axi_slv_pkg::resp_e exp_resp);
		int n;
		n       = 0;
		b_ready = ready_draw();
		while (!(b_valid && b_ready)) begin
			tick();
			n++;
			if (n > TIMEOUT) stop_with_failure("No write response arrived");
			b_ready = ready_draw();
		end
		check_val("b.id", 32'(b.id), 32'(exp_id));
		check_val("b.resp", 32'(b.resp), 32'(exp_resp));
		tick();
		b_ready  = 1'b0;
		b_done_t = $time;
	endtask

	// Out-of-range beats must come back as zero with SLVERR.
	task automatic take_r(input logic [3:0] exp_id, input int start, input int len,
			input axi_slv_pkg::burst_e bt);
		int   n;
		int   wa;
		logic ok;
		wa = start;
		for (int i = 0; i <= len; i++) begin
			n       = 0;
			r_ready = ready_draw();
			while (!(r_valid && r_ready)) begin
				tick();
				n++;
				if (n > TIMEOUT) stop_with_failure("A read beat is missing");
				r_ready = ready_draw();
			end
			ok = (wa < MEM_WORDS);
			check_val("r.data", r.data, ok ? ref_word(wa) : 32'd0);
			check_val("r.id", 32'(r.id), 32'(exp_id));
			check_val("r.resp", 32'(r.resp), ok ? 32'(axi_slv_pkg::RESP_OKAY)
				: 32'(axi_slv_pkg::RESP_SLVERR));
			check_val("r.last", 32'(r.last), 32'(i == len));
			tick();
			r_ready = 1'b0;
			wa = next_word(wa, len, bt);
		end
	endtask

	task automatic fill_beats(input int n, input logic full);
		wdata_q.delete();
		wstrb_q.delete();
		for (int i = 0; i < n; i++) begin
			wdata_q.push_back(rand_bits(32));
			wstrb_q.push_back(full ? 4'hf : 4'(rand_bits(4)));
		end
	endtask

	task automatic write_burst(input logic [3:0] id, input int start, input int len,
			input axi_slv_pkg::burst_e bt);
		axi_slv_pkg::resp_e exp_resp;
		int                 wa;
		wa       = start;
		exp_resp = axi_slv_pkg::RESP_OKAY;
		for (int i = 0; i <= len; i++) begin
			if (wa < MEM_WORDS) begin
				for (int k = 0; k < 4; k++) begin
					if (wstrb_q[i][k]) ref_mem[wa*4+k] = wdata_q[i][k*8 +: 8];
				end
			end else begin
				exp_resp = axi_slv_pkg::RESP_SLVERR;
			end
			wa = next_word(wa, len, bt);
		end
		send_aw(make_req(id, start, len, bt));
		send_w_burst();
		take_b(id, exp_resp);
	endtask

	task automatic read_burst(input logic [3:0] id, input int start, input int len,
			input axi_slv_pkg::burst_e bt);
		send_ar(make_req(id, start, len, bt));
		take_r(id, start, len, bt);
	endtask

	task automatic init_words(input int start, input int n);
		fill_beats(n, 1'b1);
		write_burst(4'h0, start, n - 1, axi_slv_pkg::BURST_INCR);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_incr();
		fill_beats(8, 1'b1);
		write_burst(4'h3, 4, 7, axi_slv_pkg::BURST_INCR);
		read_burst(4'h5, 4, 7, axi_slv_pkg::BURST_INCR);
	endtask

	// Starts at the third word of the window at word 16.
	task automatic test_wrap();
		init_words(16, 4);
		fill_beats(4, 1'b1);
		write_burst(4'h2, 18, 3, axi_slv_pkg::BURST_WRAP);
		read_burst(4'h1, 16, 3, axi_slv_pkg::BURST_INCR);
	endtask

	task automatic test_fixed();
		init_words(24, 1);
		fill_beats(4, 1'b0);
		write_burst(4'h4, 24, 3, axi_slv_pkg::BURST_FIXED);
		read_burst(4'hc, 24, 3, axi_slv_pkg::BURST_FIXED);
	endtask

	task automatic test_out_of_range();
		init_words(MEM_WORDS - 2, 2);
		fill_beats(4, 1'b1);
		write_burst(4'h9, MEM_WORDS - 2, 3, axi_slv_pkg::BURST_INCR);
		read_burst(4'ha, MEM_WORDS - 2, 3, axi_slv_pkg::BURST_INCR);
	endtask

	task automatic test_back_pressure();
		stall_en = 1'b1;
		init_words(32, 16);
		read_burst(4'hb, 32, 15, axi_slv_pkg::BURST_INCR);
		stall_en = 1'b0;
	endtask

	task automatic test_aw_ar_collision();
		fill_beats(4, 1'b1);
		fork
			write_burst(4'h6, 8, 3, axi_slv_pkg::BURST_INCR);
			read_burst(4'h7, 8, 3, axi_slv_pkg::BURST_INCR);
		join
		assert (ar_done_t > b_done_t) else begin
			stop_with_failure("The read was accepted before the write finished");
		end
	endtask

	initial begin
		lfsr      = 32'hef48_3602;
		rst_n     = 1'b0;
		aw        = '0;
		aw_valid  = 1'b0;
		w         = '0;
		w_valid   = 1'b0;
		b_ready   = 1'b0;
		ar        = '0;
		ar_valid  = 1'b0;
		r_ready   = 1'b0;
		stall_en  = 1'b0;
		b_done_t  = 0;
		ar_done_t = 0;
		repeat (5) @(posedge CLK);
		#1;
		rst_n = 1'b1;
		tick();

		test_incr();
		test_wrap();
		test_fixed();
		test_out_of_range();
		test_back_pressure();
		test_aw_ar_collision();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- testbench/axi_full_slv_sva.sv
/*
 * Protocol checks bound to the AXI4 burst slave top level.
 * The read beat count follows the last accepted AR, one read at a time.
 */

`timescale 1ns/100ps

module axi_full_slv_sva (
	input logic                  CLK,
	input logic                  rst_n,
	input axi_slv_pkg::axi_req_t aw,
	input logic                  aw_valid,
	input logic                  aw_ready,
	input axi_slv_pkg::w_beat_t  w,
	input logic                  w_valid,
	input logic                  w_ready,
	input axi_slv_pkg::b_resp_t  b,
	input logic                  b_valid,
	input logic                  b_ready,
	input axi_slv_pkg::axi_req_t ar,
	input logic                  ar_valid,
	input logic                  ar_ready,
	input axi_slv_pkg::r_beat_t  r,
	input logic                  r_valid,
	input logic                  r_ready
);

	logic [7:0] rd_len;
	logic [7:0] rd_beats;

	// Beats of the open read burst already handed over.
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			rd_len   <= '0;
			rd_beats <= '0;
		end else if (ar_valid && ar_ready) begin
			rd_len   <= ar.len;
			rd_beats <= '0;
		end else if (r_valid && r_ready) begin
			rd_beats <= rd_beats + 8'd1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Valid and payload hold until the handshake.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	aw_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw))
		else $error("AW valid or payload changed before the handshake");

	w_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		w_valid && !w_ready |=> w_valid && $stable(w))
		else $error("W valid or payload changed before the handshake");

	ar_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else $error("AR valid or payload changed before the handshake");

	b_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		b_valid && !b_ready |=> b_valid && $stable(b))
		else $error("B valid or payload changed before the handshake");

	r_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else $error("R valid or payload changed before the handshake");

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Burst framing and arbitration.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	b_after_last: assert property (@(posedge CLK) disable iff (!rst_n)
		$rose(b_valid) |-> $past(w_valid && w_ready && w.last))
		else $error("Write response raised without a last write beat");

	r_last_beat: assert property (@(posedge CLK) disable iff (!rst_n)
		r_valid |-> (r.last == (rd_beats == rd_len)))
		else $error("Read last flag does not match beat len+1");

	one_ready: assert property (@(posedge CLK) disable iff (!rst_n)
		!(aw_ready && ar_ready))
		else $error("AW and AR ready high in the same cycle");

endmodule

bind axi_full_slv axi_full_slv_sva u_sva (
	.CLK      (CLK),
	.rst_n    (rst_n),
	.aw       (aw),
	.aw_valid (aw_valid),
	.aw_ready (aw_ready),
	.w        (w),
	.w_valid  (w_valid),
	.w_ready  (w_ready),
	.b        (b),
	.b_valid  (b_valid),
	.b_ready  (b_ready),
	.ar       (ar),
	.ar_valid (ar_valid),
	.ar_ready (ar_ready),
	.r        (r),
	.r_valid  (r_valid),
	.r_ready  (r_ready)
);

//--- design/axi_full_slv.sv
/*
 * AXI4 full burst slave over an on-chip word memory of MEM_WORDS words.
 * MEM_WORDS must be a power of two, 16 or more. No outstanding queue.
 */

`timescale 1ns/100ps

module axi_full_slv #(
	parameter int MEM_WORDS = 1024
) (
	input  logic                  CLK,
	input  logic                  rst_n,

	input  axi_slv_pkg::axi_req_t aw,
	input  logic                  aw_valid,
	output logic                  aw_ready,

	input  axi_slv_pkg::w_beat_t  w,
	input  logic                  w_valid,
	output logic                  w_ready,

	output axi_slv_pkg::b_resp_t  b,
	output logic                  b_valid,
	input  logic                  b_ready,

	input  axi_slv_pkg::axi_req_t ar,
	input  logic                  ar_valid,
	output logic                  ar_ready,

	output axi_slv_pkg::r_beat_t  r,
	output logic                  r_valid,
	input  logic                  r_ready
);

	localparam int IDX_W = $clog2(MEM_WORDS);

	logic                           wr_load;
	logic                           wr_step;
	logic                           rd_load;
	logic                           rd_step;
	logic                           mem_we;
	logic [axi_slv_pkg::STRB_W-1:0] mem_strb;
	logic [axi_slv_pkg::DATA_W-1:0] mem_wdata;
	logic                           mem_re;
	logic [axi_slv_pkg::DATA_W-1:0] mem_rdata;
	logic [IDX_W-1:0]               wr_index;
	logic [IDX_W-1:0]               rd_index;
	logic                           wr_in_range;
	logic                           rd_in_range;

	axi_burst_ctrl u_ctrl (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.aw          (aw),
		.aw_valid    (aw_valid),
		.aw_ready    (aw_ready),
		.w           (w),
		.w_valid     (w_valid),
		.w_ready     (w_ready),
		.b           (b),
		.b_valid     (b_valid),
		.b_ready     (b_ready),
		.ar          (ar),
		.ar_valid    (ar_valid),
		.ar_ready    (ar_ready),
		.r           (r),
		.r_valid     (r_valid),
		.r_ready     (r_ready),
		.wr_load     (wr_load),
		.wr_step     (wr_step),
		.rd_load     (rd_load),
		.rd_step     (rd_step),
		.mem_we      (mem_we),
		.mem_strb    (mem_strb),
		.mem_wdata   (mem_wdata),
		.mem_re      (mem_re),
		.wr_in_range (wr_in_range),
		.rd_in_range (rd_in_range),
		.mem_rdata   (mem_rdata)
	);

	// One address sequencer per direction.
	burst_addr_gen #(.MEM_WORDS(MEM_WORDS)) u_wr_addr (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.load     (wr_load),
		.step     (wr_step),
		.req      (aw),
		.index    (wr_index),
		.in_range (wr_in_range)
	);

	burst_addr_gen #(.MEM_WORDS(MEM_WORDS)) u_rd_addr (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.load     (rd_load),
		.step     (rd_step),
		.req      (ar),
		.index    (rd_index),
		.in_range (rd_in_range)
	);

	slv_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
		.CLK   (CLK),
		.we    (mem_we),
		.strb  (mem_strb),
		.waddr (wr_index),
		.wdata (mem_wdata),
		.re    (mem_re),
		.raddr (rd_index),
		.rdata (mem_rdata)
	);

endmodule

//--- design/axi_burst_ctrl.sv
/*
 * Channel controller of the AXI4 slave. One transaction at a time; AW wins
 * over AR when both are pending. Write bursts end on w.last, not on len.
 */

`timescale 1ns/100ps

module axi_burst_ctrl (
	input  logic                           CLK,
	input  logic                           rst_n,
	input  axi_slv_pkg::axi_req_t          aw,
	input  logic                           aw_valid,
	output logic                           aw_ready,
	input  axi_slv_pkg::w_beat_t           w,
	input  logic                           w_valid,
	output logic                           w_ready,
	output axi_slv_pkg::b_resp_t           b,
	output logic                           b_valid,
	input  logic                           b_ready,
	input  axi_slv_pkg::axi_req_t          ar,
	input  logic                           ar_valid,
	output logic                           ar_ready,
	output axi_slv_pkg::r_beat_t           r,
	output logic                           r_valid,
	input  logic                           r_ready,
	output logic                           wr_load,
	output logic                           wr_step,
	output logic                           rd_load,
	output logic                           rd_step,
	output logic                           mem_we,
	output logic [axi_slv_pkg::STRB_W-1:0] mem_strb,
	output logic [axi_slv_pkg::DATA_W-1:0] mem_wdata,
	output logic                           mem_re,
	input  logic                           wr_in_range,
	input  logic                           rd_in_range,
	input  logic [axi_slv_pkg::DATA_W-1:0] mem_rdata
);

	typedef enum logic [1:0] {IDLE, WRITE, WRESP, READ} state_e;

	state_e                       state;
	logic [axi_slv_pkg::ID_W-1:0] id_q;
	logic [7:0]                   len_q;
	logic [7:0]                   beat_cnt;
	logic                         err_q;
	logic                         rd_pend;
	logic                         r_last_q;
	logic                         rd_oor_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Strobes to the address generators and the memory.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign wr_load   = aw_valid & aw_ready;
	assign wr_step   = w_valid & w_ready;
	assign rd_load   = ar_valid & ar_ready;
	assign rd_step   = r_valid & r_ready & ~r_last_q;
	assign mem_we    = w_valid & w_ready & wr_in_range;
	assign mem_strb  = w.strb;
	assign mem_wdata = w.data;
	assign mem_re    = rd_pend;

	assign b.id   = id_q;
	assign b.resp = err_q ? axi_slv_pkg::RESP_SLVERR : axi_slv_pkg::RESP_OKAY;

	// Out-of-range read beats carry zero data.
	assign r.id   = id_q;
	assign r.data = rd_oor_q ? '0 : mem_rdata;
	assign r.resp = rd_oor_q ? axi_slv_pkg::RESP_SLVERR : axi_slv_pkg::RESP_OKAY;
	assign r.last = r_last_q;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state    <= IDLE;
			aw_ready <= 1'b0;
			w_ready  <= 1'b0;
			b_valid  <= 1'b0;
			ar_ready <= 1'b0;
			r_valid  <= 1'b0;
			id_q     <= '0;
			len_q    <= '0;
			beat_cnt <= '0;
			err_q    <= 1'b0;
			rd_pend  <= 1'b0;
			r_last_q <= 1'b0;
			rd_oor_q <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					// Ready is offered for one cycle, then arbitration starts again.
					if (aw_ready) begin
						aw_ready <= 1'b0;
						if (aw_valid) begin
							state   <= WRITE;
							w_ready <= 1'b1;
							id_q    <= aw.id;
							err_q   <= 1'b0;
						end
					end else if (ar_ready) begin
						ar_ready <= 1'b0;
						if (ar_valid) begin
							state    <= READ;
							rd_pend  <= 1'b1;
							id_q     <= ar.id;
							len_q    <= ar.len;
							beat_cnt <= '0;
						end
					end else if (aw_valid) begin
						aw_ready <= 1'b1;
					end else if (ar_valid) begin
						ar_ready <= 1'b1;
					end
				end
				WRITE: begin
					if (w_valid) begin
						err_q <= err_q | ~wr_in_range;
						if (w.last) begin
							w_ready <= 1'b0;
							b_valid <= 1'b1;
							state   <= WRESP;
						end
					end
				end
				WRESP: begin
					if (b_ready) begin
						b_valid <= 1'b0;
						state   <= IDLE;
					end
				end
				READ: begin
					// The read issued last cycle lands with r_valid.
					if (rd_pend) begin
						rd_pend  <= 1'b0;
						r_valid  <= 1'b1;
						r_last_q <= (beat_cnt == len_q);
						rd_oor_q <= ~rd_in_range;
					end else if (r_valid && r_ready) begin
						r_valid <= 1'b0;
						if (r_last_q) begin
							state <= IDLE;
						end else begin
							rd_pend  <= 1'b1;
							beat_cnt <= beat_cnt + 8'd1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- design/slv_mem.sv
/*
 * Single-clock word memory, byte-strobed write and one-cycle read.
 * Contents are unknown after power-up. A same-cycle read sees old data.
 */

`timescale 1ns/100ps

module slv_mem #(
	parameter int MEM_WORDS = 1024
) (
	input  logic                              CLK,
	input  logic                              we,
	input  logic [axi_slv_pkg::STRB_W-1:0]    strb,
	input  logic [$clog2(MEM_WORDS)-1:0]      waddr,
	input  logic [axi_slv_pkg::DATA_W-1:0]    wdata,
	input  logic                              re,
	input  logic [$clog2(MEM_WORDS)-1:0]      raddr,
	output logic [axi_slv_pkg::DATA_W-1:0]    rdata
);

	logic [axi_slv_pkg::DATA_W-1:0] mem [MEM_WORDS];

	// Each lane is written only when its strobe bit is set.
	always_ff @(posedge CLK) begin
		if (we) begin
			for (int i = 0; i < axi_slv_pkg::STRB_W; i++) begin
				if (strb[i]) begin
					mem[waddr][i*8 +: 8] <= wdata[i*8 +: 8];
				end
			end
		end
	end

	// The read word holds until the next read is issued.
	always_ff @(posedge CLK) begin
		if (re) begin
			rdata <= mem[raddr];
		end
	end

endmodule

//--- design/burst_addr_gen.sv
/*
 * Word address sequencer for one AXI burst. The low address bits below a
 * word are dropped. WRAP needs len+1 to be 2, 4, 8 or 16 words.
 */

`timescale 1ns/100ps

module burst_addr_gen #(
	parameter int MEM_WORDS = 1024
) (
	input  logic                         CLK,
	input  logic                         rst_n,
	input  logic                         load,
	input  logic                         step,
	input  axi_slv_pkg::axi_req_t        req,
	output logic [$clog2(MEM_WORDS)-1:0] index,
	output logic                         in_range
);

	localparam int ADDR_LSB = $clog2(axi_slv_pkg::STRB_W);
	localparam int WA_W     = axi_slv_pkg::ADDR_W - ADDR_LSB;
	localparam int IDX_W    = $clog2(MEM_WORDS);

	logic [WA_W-1:0]            waddr_q;
	logic [7:0]                 len_q;
	axi_slv_pkg::burst_e        burst_q;
	logic [WA_W-1:0]            wrap_mask;
	logic [WA_W-1:0]            waddr_nxt;

	// For WRAP the window size is len+1 words, so len itself is the mask.
	assign wrap_mask = {{(WA_W-8){1'b0}}, len_q};

	always_comb begin
		case (burst_q)
			axi_slv_pkg::BURST_FIXED: waddr_nxt = waddr_q;
			axi_slv_pkg::BURST_WRAP:
				waddr_nxt = (waddr_q & ~wrap_mask) | ((waddr_q + 1'b1) & wrap_mask);
			default: waddr_nxt = waddr_q + 1'b1;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			waddr_q <= '0;
			len_q   <= '0;
			burst_q <= axi_slv_pkg::BURST_INCR;
		end else if (load) begin
			waddr_q <= req.addr[axi_slv_pkg::ADDR_W-1:ADDR_LSB];
			len_q   <= req.len;
			burst_q <= req.burst;
		end else if (step) begin
			waddr_q <= waddr_nxt;
		end
	end

	assign index    = waddr_q[IDX_W-1:0];
	assign in_range = (waddr_q < WA_W'(MEM_WORDS));

endmodule

//--- design/axi_slv_pkg.sv
/*
 * Shared widths, codes and channel structs of the AXI4 burst slave.
 * Every beat is one full 32-bit word. SIZE, LOCK, CACHE, PROT, QOS,
 * REGION and USER are not carried on the channels.
 */

package axi_slv_pkg;

	parameter int DATA_W = 32;
	parameter int ADDR_W = 32;
	parameter int ID_W   = 4;
	parameter int STRB_W = DATA_W / 8;

	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} burst_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Channel payloads. The address request serves both AW and AR.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;
		burst_e            burst;
	} axi_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		logic              last;
	} w_beat_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		resp_e           resp;
	} b_resp_t;

	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [DATA_W-1:0] data;
		resp_e             resp;
		logic              last;
	} r_beat_t;

endpackage
